/* hdl/rv32i_isa_pkg.sv */
`default_nettype none

package rv32i_isa_pkg;

  localparam int unsigned XLEN   = 32;
  localparam int unsigned MASK_W = XLEN / 8;  // One lane per byte

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [4:0]        reg_idx_t;
  typedef logic [MASK_W-1:0] mask_t;

  // Major opcodes from instruction bits [6:0]
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } opcode_t;

  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
  } store_funct3_t;

  // 010 and 011 are unused
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

endpackage : rv32i_isa_pkg

`default_nettype wire

/* hdl/mem_stage_pkg.sv */
`default_nettype none

package mem_stage_pkg;

  // Source of the value written back to the register file
  typedef enum logic [3:0] {
    alu_out,
    br_en,
    u_imm,
    pc_plus4,
    lw,
    lh,
    lhu,
    lb,
    lbu
  } wb_sel_t;

  // EX/MEM entry where all zero is a bubble
  typedef struct packed {
    logic                   valid;
    rv32i_isa_pkg::opcode_t opcode;
    logic [2:0]             funct3;
    wb_sel_t                wb_sel;
    logic                   load_regfile;
    logic                   mem_read;
    logic                   mem_write;
    rv32i_isa_pkg::reg_idx_t rd;
    rv32i_isa_pkg::word_t   pc;
    rv32i_isa_pkg::word_t   alu_out;      // Also the data address
    rv32i_isa_pkg::word_t   imm;
    rv32i_isa_pkg::word_t   rs2_data;     // Store data
    logic                   br_en;
  } ex_mem_t;

  typedef struct packed {
    logic                 read;
    logic                 write;
    rv32i_isa_pkg::word_t address;       // Word aligned
    rv32i_isa_pkg::word_t wdata;
    rv32i_isa_pkg::mask_t byte_enable;
  } dcache_req_t;

  typedef struct packed {
    logic                    valid;
    logic                    load_regfile;
    rv32i_isa_pkg::reg_idx_t rd;
    rv32i_isa_pkg::word_t    value;
    rv32i_isa_pkg::mask_t    rmask;
    rv32i_isa_pkg::mask_t    wmask;
    logic                    trap;
  } mem_wb_t;

endpackage : mem_stage_pkg

`default_nettype wire

/* hdl/ex_mem_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_capture (
  input  wire logic                   clk,
  input  wire logic                   i_rst,
  input  wire mem_stage_pkg::ex_mem_t i_ex,
  input  wire logic                   i_flush,
  input  wire logic                   i_hold,
  output mem_stage_pkg::ex_mem_t      o_entry,
  output rv32i_isa_pkg::mask_t        o_rmask,
  output rv32i_isa_pkg::mask_t        o_wmask,
  output logic                        o_trap
);

  logic                 is_load;
  logic                 is_store;
  logic                 illegal;
  logic [1:0]           size;        // log2 of access bytes
  logic [1:0]           offset;
  logic                 misaligned;
  rv32i_isa_pkg::mask_t lanes;

  // Flush only counts when the stage is free to move
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_entry <= '0;
    end else if (!i_hold) begin
      if (i_flush) begin
        o_entry <= '0;  // Bubble
      end else begin
        o_entry <= i_ex;
      end
    end
  end

  always_comb begin : decode
    is_load  = 1'b0;
    is_store = 1'b0;
    illegal  = 1'b0;
    size     = 2'd0;
    if (o_entry.valid) begin
      case (o_entry.opcode)
        rv32i_isa_pkg::op_lui, rv32i_isa_pkg::op_auipc, rv32i_isa_pkg::op_jal,
        rv32i_isa_pkg::op_jalr, rv32i_isa_pkg::op_imm, rv32i_isa_pkg::op_reg: ;
        rv32i_isa_pkg::op_br: begin
          case (rv32i_isa_pkg::branch_funct3_t'(o_entry.funct3))
            rv32i_isa_pkg::beq, rv32i_isa_pkg::bne, rv32i_isa_pkg::blt,
            rv32i_isa_pkg::bge, rv32i_isa_pkg::bltu, rv32i_isa_pkg::bgeu: ;
            default: illegal = 1'b1;
          endcase
        end
        rv32i_isa_pkg::op_load: begin
          is_load = 1'b1;
          case (rv32i_isa_pkg::load_funct3_t'(o_entry.funct3))
            rv32i_isa_pkg::lb, rv32i_isa_pkg::lbu: size = 2'd0;
            rv32i_isa_pkg::lh, rv32i_isa_pkg::lhu: size = 2'd1;
            rv32i_isa_pkg::lw:                     size = 2'd2;
            default:                               illegal = 1'b1;
          endcase
        end
        rv32i_isa_pkg::op_store: begin
          is_store = 1'b1;
          case (rv32i_isa_pkg::store_funct3_t'(o_entry.funct3))
            rv32i_isa_pkg::sb: size = 2'd0;
            rv32i_isa_pkg::sh: size = 2'd1;
            rv32i_isa_pkg::sw: size = 2'd2;
            default:           illegal = 1'b1;
          endcase
        end
        default: illegal = 1'b1;  // Unknown opcode
      endcase
    end
  end

  assign offset = o_entry.alu_out[1:0];

  // Words need offset 0, halves an even offset
  assign misaligned = (is_load || is_store) &&
                      ((size == 2'd2 && offset != 2'd0) || (size == 2'd1 && offset[0]));

  always_comb begin : lane_pick
    case (size)
      2'd2:    lanes = 4'b1111;
      2'd1:    lanes = 4'b0011 << offset;
      default: lanes = 4'b0001 << offset;
    endcase
  end

  assign o_trap  = illegal || misaligned;
  assign o_rmask = (is_load && !o_trap) ? lanes : '0;
  assign o_wmask = (is_store && !o_trap) ? lanes : '0;

endmodule : ex_mem_capture

`default_nettype wire

/* hdl/dcache_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_port (
  input  wire mem_stage_pkg::ex_mem_t i_entry,
  input  wire rv32i_isa_pkg::mask_t   i_wmask,
  input  wire logic                   i_trap,
  input  wire logic                   i_dmem_resp,
  output mem_stage_pkg::dcache_req_t  o_dmem,
  output logic                        o_stall
);

  logic req;

  // Trapped or empty entries never reach the cache
  assign req = i_entry.valid && !i_trap && (i_entry.mem_read || i_entry.mem_write);

  always_comb begin : build_req
    o_dmem.read        = req && i_entry.mem_read;
    o_dmem.write       = req && i_entry.mem_write && !i_entry.mem_read;  // Read wins
    o_dmem.address     = {i_entry.alu_out[31:2], 2'b00};
    o_dmem.wdata       = i_entry.rs2_data;
    o_dmem.byte_enable = i_wmask;
  end

  // Request level stays up until the response cycle
  assign o_stall = req && !i_dmem_resp;

endmodule : dcache_port

`default_nettype wire

/* hdl/wb_select.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_select (
  input  wire logic                   clk,
  input  wire logic                   i_rst,
  input  wire mem_stage_pkg::ex_mem_t i_entry,
  input  wire rv32i_isa_pkg::mask_t   i_rmask,
  input  wire rv32i_isa_pkg::mask_t   i_wmask,
  input  wire logic                   i_trap,
  input  wire logic                   i_hold,
  input  wire rv32i_isa_pkg::word_t   i_dmem_rdata,
  output mem_stage_pkg::mem_wb_t      o_wb
);

  rv32i_isa_pkg::word_t    shifted;
  rv32i_isa_pkg::word_t    load_value;
  rv32i_isa_pkg::word_t    value;

  logic                    wb_valid;
  logic                    wb_load;
  logic                    wb_trap;
  rv32i_isa_pkg::reg_idx_t wb_rd;
  rv32i_isa_pkg::word_t    wb_value;
  rv32i_isa_pkg::mask_t    wb_rmask;
  rv32i_isa_pkg::mask_t    wb_wmask;

  // Addressed byte moved down to lane 0
  assign shifted = i_dmem_rdata >> {i_entry.alu_out[1:0], 3'b000};

  always_comb begin : load_extend
    case (rv32i_isa_pkg::load_funct3_t'(i_entry.funct3))
      rv32i_isa_pkg::lb:  load_value = {{24{shifted[7]}}, shifted[7:0]};
      rv32i_isa_pkg::lbu: load_value = {24'b0, shifted[7:0]};
      rv32i_isa_pkg::lh:  load_value = {{16{shifted[15]}}, shifted[15:0]};
      rv32i_isa_pkg::lhu: load_value = {16'b0, shifted[15:0]};
      default:            load_value = shifted;
    endcase
  end

  always_comb begin : value_mux
    case (i_entry.wb_sel)
      mem_stage_pkg::alu_out:  value = i_entry.alu_out;
      mem_stage_pkg::br_en:    value = {{(rv32i_isa_pkg::XLEN-1){1'b0}}, i_entry.br_en};
      mem_stage_pkg::u_imm:    value = i_entry.imm;
      mem_stage_pkg::pc_plus4: value = i_entry.pc + 32'd4;
      mem_stage_pkg::lw, mem_stage_pkg::lh, mem_stage_pkg::lhu,
      mem_stage_pkg::lb, mem_stage_pkg::lbu: begin
        value = load_value;  // Width and sign from funct3
      end
      default:                 value = '0;
    endcase
    if (i_trap) begin
      value = '0;
    end
  end

  // Each entry retires once; a held slot drops its valid
  always_ff @(posedge clk) begin
    if (i_rst) begin
      wb_valid <= 1'b0;
      wb_load  <= 1'b0;
      wb_trap  <= 1'b0;
    end else if (i_hold) begin
      wb_valid <= 1'b0;
      wb_load  <= 1'b0;
      wb_trap  <= 1'b0;
    end else begin
      wb_valid <= i_entry.valid;
      wb_load  <= i_entry.valid && i_entry.load_regfile && !i_trap;
      wb_trap  <= i_trap;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_hold) begin
      wb_rd    <= i_entry.rd;
      wb_value <= value;
      wb_rmask <= i_rmask;
      wb_wmask <= i_wmask;
    end
  end

  always_comb begin : pack_out
    o_wb.valid        = wb_valid;
    o_wb.load_regfile = wb_load;
    o_wb.rd           = wb_rd;
    o_wb.value        = wb_value;
    o_wb.rmask        = wb_rmask;
    o_wb.wmask        = wb_wmask;
    o_wb.trap         = wb_trap;
  end

endmodule : wb_select

`default_nettype wire

/* hdl/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  wire logic                   clk,
  input  wire logic                   i_rst,
  input  wire mem_stage_pkg::ex_mem_t i_ex,
  input  wire logic                   i_flush,
  input  wire logic                   i_dmem_resp,
  input  wire rv32i_isa_pkg::word_t   i_dmem_rdata,
  output mem_stage_pkg::dcache_req_t  o_dmem,
  output logic                        o_stall,
  output mem_stage_pkg::mem_wb_t      o_wb
);

  mem_stage_pkg::ex_mem_t entry;
  rv32i_isa_pkg::mask_t   entry_rmask;
  rv32i_isa_pkg::mask_t   entry_wmask;
  logic                   entry_trap;

  ex_mem_capture u_capture (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_ex    (i_ex),
    .i_flush (i_flush),
    .i_hold  (o_stall),
    .o_entry (entry),
    .o_rmask (entry_rmask),
    .o_wmask (entry_wmask),
    .o_trap  (entry_trap)
  );

  dcache_port u_dcache_port (
    .i_entry     (entry),
    .i_wmask     (entry_wmask),
    .i_trap      (entry_trap),
    .i_dmem_resp (i_dmem_resp),
    .o_dmem      (o_dmem),
    .o_stall     (o_stall)
  );

  wb_select u_wb_select (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_entry      (entry),
    .i_rmask      (entry_rmask),
    .i_wmask      (entry_wmask),
    .i_trap       (entry_trap),
    .i_hold       (o_stall),
    .i_dmem_rdata (i_dmem_rdata),
    .o_wb         (o_wb)
  );

endmodule : mem_stage

`default_nettype wire

/* include/mem_stage_model.svh */
`ifndef MEM_STAGE_MODEL_SVH
`define MEM_STAGE_MODEL_SVH

// Galois LFSR with taps 32 22 2 1
// Stimulus bit is state[0]
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  lfsr_next = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// Data memory word after a write with byte enables
function automatic rv32i_isa_pkg::word_t merge_bytes(input rv32i_isa_pkg::word_t old,
                                                     input rv32i_isa_pkg::word_t wdata,
                                                     input rv32i_isa_pkg::mask_t be);
  rv32i_isa_pkg::word_t r;
  r = old;
  for (int b = 0; b < 4; b++) begin
    if (be[b]) begin
      r[8*b +: 8] = wdata[8*b +: 8];
    end
  end
  return r;
endfunction

// Expected MEM/WB result; rdata is the memory word at the entry's address
function automatic mem_stage_pkg::mem_wb_t model_wb(input mem_stage_pkg::ex_mem_t e,
                                                    input rv32i_isa_pkg::word_t rdata);
  mem_stage_pkg::mem_wb_t wb;
  logic [1:0]             off;
  int unsigned            bytes;
  logic                   legal;
  rv32i_isa_pkg::word_t   data;
  rv32i_isa_pkg::mask_t   lanes;
  wb    = '0;
  off   = e.alu_out[1:0];
  bytes = 0;
  legal = 1'b1;
  case (e.opcode)
    rv32i_isa_pkg::op_load, rv32i_isa_pkg::op_store: begin
      case (e.funct3)
        3'b000:  bytes = 1;
        3'b001:  bytes = 2;
        3'b010:  bytes = 4;
        3'b100, 3'b101: bytes = (e.opcode == rv32i_isa_pkg::op_load) ? (e.funct3[0] ? 2 : 1) : 0;
        default: bytes = 0;
      endcase
      legal = (bytes != 0) && (off % bytes == 0);
    end
    rv32i_isa_pkg::op_br:  legal = !(e.funct3 inside {3'b010, 3'b011});
    rv32i_isa_pkg::op_lui, rv32i_isa_pkg::op_auipc, rv32i_isa_pkg::op_jal,
    rv32i_isa_pkg::op_jalr, rv32i_isa_pkg::op_imm, rv32i_isa_pkg::op_reg: legal = 1'b1;
    default: legal = 1'b0;
  endcase
  wb.valid = e.valid;
  wb.rd    = e.rd;
  wb.trap  = !legal;
  if (!legal) begin
    return wb;
  end
  lanes = rv32i_isa_pkg::mask_t'(((1 << bytes) - 1) << off);
  if (e.opcode == rv32i_isa_pkg::op_load) begin
    wb.rmask = lanes;
  end
  if (e.opcode == rv32i_isa_pkg::op_store) begin
    wb.wmask = lanes;
  end
  data = rdata >> (8 * off);
  case (e.wb_sel)
    mem_stage_pkg::alu_out:  wb.value = e.alu_out;
    mem_stage_pkg::br_en:    wb.value = {31'b0, e.br_en};
    mem_stage_pkg::u_imm:    wb.value = e.imm;
    mem_stage_pkg::pc_plus4: wb.value = e.pc + 32'd4;
    mem_stage_pkg::lw, mem_stage_pkg::lh, mem_stage_pkg::lhu,
    mem_stage_pkg::lb, mem_stage_pkg::lbu: begin
      case (e.funct3)
        3'b000:  wb.value = {{24{data[7]}}, data[7:0]};
        3'b001:  wb.value = {{16{data[15]}}, data[15:0]};
        3'b100:  wb.value = {24'b0, data[7:0]};
        3'b101:  wb.value = {16'b0, data[15:0]};
        default: wb.value = data;
      endcase
    end
    default: wb.value = '0;
  endcase
  wb.load_regfile = e.valid && e.load_regfile;
  return wb;
endfunction

`endif

/* sim/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

  `include "mem_stage_model.svh"

  localparam int RESET_CYCLES = 16;
  localparam int N_NONMEM     = 40;
  localparam int N_LOAD       = 60;
  localparam int N_STORE      = 30;  // Each followed by a lw
  localparam int N_TRAP       = 40;
  localparam int N_FLUSH      = 40;
  localparam int TOTAL        = N_NONMEM + N_LOAD + 2 * N_STORE + N_TRAP + N_FLUSH;
  localparam int CYCLE_LIMIT  = 5 * TOTAL + RESET_CYCLES;

  logic                       clk = 1'b0;
  logic                       i_rst;
  mem_stage_pkg::ex_mem_t     i_ex;
  logic                       i_flush;
  logic                       i_dmem_resp;
  rv32i_isa_pkg::word_t       i_dmem_rdata;
  mem_stage_pkg::dcache_req_t o_dmem;
  logic                       o_stall;
  mem_stage_pkg::mem_wb_t     o_wb;

  logic [31:0]                lfsr_state = 32'd15;
  rv32i_isa_pkg::word_t       ref_mem [64];    // Memory as the model expects it
  rv32i_isa_pkg::word_t       cache_mem [64];  // Memory behind the DUT's port
  mem_stage_pkg::mem_wb_t     exp_wb_q [$];
  mem_stage_pkg::dcache_req_t exp_req_q [$];
  logic                       req_busy = 1'b0;
  int unsigned                req_wait;
  int                         cycles;
  int                         checks;
  int                         errors;
  int                         test_errors;
  int                         tests_run;
  int                         tests_failed;

  mem_stage dut0 (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_ex         (i_ex),
    .i_flush      (i_flush),
    .i_dmem_resp  (i_dmem_resp),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem       (o_dmem),
    .o_stall      (o_stall),
    .o_wb         (o_wb)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, DUT stopped making progress", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %s expected %h got %h", name, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("%s at cycle %0d", msg, cycles);
    errors++;
    test_errors++;
  endtask

  function automatic mem_stage_pkg::wb_sel_t load_sel(input logic [2:0] funct3);
    case (funct3)
      3'b000:  return mem_stage_pkg::lb;
      3'b001:  return mem_stage_pkg::lh;
      3'b100:  return mem_stage_pkg::lbu;
      3'b101:  return mem_stage_pkg::lhu;
      default: return mem_stage_pkg::lw;
    endcase
  endfunction

  function automatic mem_stage_pkg::ex_mem_t base_entry();
    mem_stage_pkg::ex_mem_t e;
    e              = '0;
    e.valid        = 1'b1;
    e.rd           = 5'(rand_bits(5));
    e.pc           = rand_bits(32);
    e.alu_out      = rand_bits(32);
    e.imm          = rand_bits(32);
    e.rs2_data     = rand_bits(32);
    e.br_en        = 1'(rand_bits(1));
    e.load_regfile = 1'(rand_bits(1));
    e.funct3       = 3'(rand_bits(3));
    e.wb_sel       = mem_stage_pkg::alu_out;
    return e;
  endfunction

  function automatic mem_stage_pkg::ex_mem_t nonmem_entry();
    mem_stage_pkg::ex_mem_t e;
    e = base_entry();
    case (rand_bits(3) % 7)
      0: e.opcode = rv32i_isa_pkg::op_lui;
      1: e.opcode = rv32i_isa_pkg::op_auipc;
      2: e.opcode = rv32i_isa_pkg::op_jal;
      3: e.opcode = rv32i_isa_pkg::op_jalr;
      4: e.opcode = rv32i_isa_pkg::op_imm;
      5: e.opcode = rv32i_isa_pkg::op_reg;
      default: begin
        e.opcode = rv32i_isa_pkg::op_br;
        if (e.funct3[2:1] == 2'b01) begin
          e.funct3[2] = 1'b1;  // Skip the two unused codes
        end
      end
    endcase
    case (rand_bits(2))
      0:       e.wb_sel = mem_stage_pkg::alu_out;
      1:       e.wb_sel = mem_stage_pkg::br_en;
      2:       e.wb_sel = mem_stage_pkg::u_imm;
      default: e.wb_sel = mem_stage_pkg::pc_plus4;
    endcase
    return e;
  endfunction

  // Legal load or store aligned for its width within words 0..15
  function automatic mem_stage_pkg::ex_mem_t mem_entry(input logic store);
    mem_stage_pkg::ex_mem_t e;
    logic [1:0]             w;
    logic [1:0]             off;
    logic                   sgn;
    e   = base_entry();
    w   = 2'(rand_bits(2));
    off = 2'(rand_bits(2));
    sgn = 1'(rand_bits(1));
    if (w == 2'd3) begin
      w = 2'd2;
    end
    if (w == 2'd2) begin
      off = 2'd0;
    end else if (w == 2'd1) begin
      off[0] = 1'b0;
    end
    e.opcode       = store ? rv32i_isa_pkg::op_store : rv32i_isa_pkg::op_load;
    e.mem_read     = !store;
    e.mem_write    = store;
    e.load_regfile = !store;
    e.funct3       = {!store && !sgn && w != 2'd2, w};
    e.alu_out[7:0] = {2'b00, 4'(rand_bits(4)), off};
    e.wb_sel       = store ? mem_stage_pkg::alu_out : load_sel(e.funct3);
    return e;
  endfunction

  function automatic mem_stage_pkg::ex_mem_t trap_entry();
    mem_stage_pkg::ex_mem_t e;
    logic [2:0]             f;
    logic [6:0]             op;
    e = mem_entry(1'(rand_bits(1)));
    f = 3'(rand_bits(3));
    case (rand_bits(3) % 5)
      0: begin  // Word off its boundary
        e.funct3       = 3'b010;
        e.alu_out[1:0] = (f[1:0] == 2'b00) ? 2'b10 : f[1:0];
      end
      1: begin  // Odd halfword
        e.funct3     = {e.mem_read & f[2], 2'b01};
        e.alu_out[0] = 1'b1;
      end
      2: begin
        if (e.mem_read) begin
          e.funct3 = f[2] ? {2'b11, f[0]} : 3'b011;
        end else begin
          e.funct3 = (f < 3'd3) ? 3'b011 : f;
        end
      end
      3: begin
        e.opcode = rv32i_isa_pkg::op_br;
        e.funct3 = {2'b01, f[0]};
      end
      default: begin
        op = 7'(rand_bits(7));
        while (op inside {7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33}) begin
          op = 7'(rand_bits(7));
        end
        e.opcode = rv32i_isa_pkg::opcode_t'(op);
      end
    endcase
    e.wb_sel = e.mem_write ? mem_stage_pkg::alu_out : load_sel(e.funct3);
    return e;
  endfunction

  // Responds to the request that is up in this cycle
  task automatic serve_cache();
    mem_stage_pkg::dcache_req_t exp;
    logic [5:0]                 idx;
    i_dmem_resp  = 1'b0;
    i_dmem_rdata = rand_bits(32);  // Junk outside a read response
    if (o_dmem.read && o_dmem.write) begin
      report_fail("Cache read and write requested together");
    end
    if (o_dmem.read || o_dmem.write) begin
      if (!req_busy) begin
        req_busy = 1'b1;
        req_wait = rand_bits(2);
        if (exp_req_q.size() == 0) begin
          report_fail("Cache request seen with none expected");
        end else begin
          exp = exp_req_q.pop_front();
          check_field("o_dmem.read", 32'(exp.read), 32'(o_dmem.read));
          check_field("o_dmem.write", 32'(exp.write), 32'(o_dmem.write));
          check_field("o_dmem.address", exp.address, o_dmem.address);
          check_field("o_dmem.wdata", exp.wdata, o_dmem.wdata);
          check_field("o_dmem.byte_enable", 32'(exp.byte_enable), 32'(o_dmem.byte_enable));
        end
      end
      if (req_wait == 0) begin
        idx         = o_dmem.address[7:2];
        i_dmem_resp = 1'b1;
        req_busy    = 1'b0;
        if (o_dmem.read) begin
          i_dmem_rdata = cache_mem[idx];
        end else begin
          cache_mem[idx] = merge_bytes(cache_mem[idx], o_dmem.wdata, o_dmem.byte_enable);
        end
      end else begin
        req_wait--;
      end
    end
  endtask

  // Checks o_wb, serves the cache and drives i_ex, then sees if it is taken
  task automatic run_cycle(input mem_stage_pkg::ex_mem_t e, input logic fl, output logic taken);
    mem_stage_pkg::mem_wb_t exp;
    @(posedge clk);
    #2;
    if (o_wb.valid) begin
      if (exp_wb_q.size() == 0) begin
        report_fail("Write-back entry seen with none expected");
      end else begin
        exp = exp_wb_q.pop_front();
        check_field("o_wb.value", exp.value, o_wb.value);
        check_field("o_wb.rd", 32'(exp.rd), 32'(o_wb.rd));
        check_field("o_wb.load_regfile", 32'(exp.load_regfile), 32'(o_wb.load_regfile));
        check_field("o_wb.rmask", 32'(exp.rmask), 32'(o_wb.rmask));
        check_field("o_wb.wmask", 32'(exp.wmask), 32'(o_wb.wmask));
        check_field("o_wb.trap", 32'(exp.trap), 32'(o_wb.trap));
      end
    end
    serve_cache();
    i_ex    = e;
    i_flush = fl;
    #1;
    taken = !o_stall;
  endtask

  task automatic expect_entry(input mem_stage_pkg::ex_mem_t e);
    mem_stage_pkg::mem_wb_t     wb;
    mem_stage_pkg::dcache_req_t req;
    logic [5:0]                 idx;
    idx = e.alu_out[7:2];
    wb  = model_wb(e, ref_mem[idx]);
    exp_wb_q.push_back(wb);
    if (wb.rmask != '0 || wb.wmask != '0) begin
      req.read        = (wb.rmask != '0);
      req.write       = (wb.wmask != '0);
      req.address     = {e.alu_out[31:2], 2'b00};
      req.wdata       = e.rs2_data;
      req.byte_enable = wb.wmask;
      exp_req_q.push_back(req);
      ref_mem[idx] = merge_bytes(ref_mem[idx], e.rs2_data, wb.wmask);
    end
  endtask

  task automatic present(input mem_stage_pkg::ex_mem_t e, input logic fl);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      run_cycle(e, fl, taken);
    end
    if (e.valid && !fl) begin
      expect_entry(e);  // Flushed entries leave no trace
    end
  endtask

  task automatic end_test(input string name);
    logic taken;
    while (exp_wb_q.size() != 0 || exp_req_q.size() != 0) begin
      run_cycle('0, 1'b0, taken);
    end
    repeat (2) run_cycle('0, 1'b0, taken);  // Catch stray outputs
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAIL", test_errors);
    test_errors = 0;
  endtask

  initial begin
    mem_stage_pkg::ex_mem_t e;
    logic                   fl;
    i_rst        = 1'b1;
    i_ex         = '0;
    i_flush      = 1'b0;
    i_dmem_resp  = 1'b0;
    i_dmem_rdata = '0;
    for (int i = 0; i < 64; i++) begin
      ref_mem[i]   = 32'h9e37_79b9 * (i + 1);
      cache_mem[i] = ref_mem[i];
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    i_rst = 1'b0;
    #1;
    check_field("o_dmem.read", 32'd0, 32'(o_dmem.read));
    check_field("o_dmem.write", 32'd0, 32'(o_dmem.write));
    check_field("o_stall", 32'd0, 32'(o_stall));
    check_field("o_wb.valid", 32'd0, 32'(o_wb.valid));
    check_field("o_wb.load_regfile", 32'd0, 32'(o_wb.load_regfile));
    check_field("o_wb.trap", 32'd0, 32'(o_wb.trap));
    end_test("reset");

    for (int i = 0; i < N_NONMEM; i++) begin
      present(nonmem_entry(), 1'b0);
    end
    end_test("non_memory");

    for (int i = 0; i < N_LOAD; i++) begin
      present(mem_entry(1'b0), 1'b0);
    end
    end_test("loads");

    for (int i = 0; i < N_STORE; i++) begin
      e = mem_entry(1'b1);
      present(e, 1'b0);
      e.opcode       = rv32i_isa_pkg::op_load;  // Read back the whole word
      e.funct3       = 3'b010;
      e.wb_sel       = mem_stage_pkg::lw;
      e.mem_read     = 1'b1;
      e.mem_write    = 1'b0;
      e.load_regfile = 1'b1;
      e.alu_out[1:0] = 2'b00;
      present(e, 1'b0);
    end
    end_test("stores");

    for (int i = 0; i < N_TRAP; i++) begin
      present(trap_entry(), 1'b0);
    end
    end_test("traps");

    for (int i = 0; i < N_FLUSH; i++) begin
      case (rand_bits(2))
        0:       e = nonmem_entry();
        1:       e = mem_entry(1'b0);
        2:       e = mem_entry(1'b1);
        default: e = trap_entry();
      endcase
      fl = (rand_bits(2) == 0);  // About one in four
      present(e, fl);
    end
    end_test("flush");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_mem_stage

`default_nettype wire

/* sim.f */
+incdir+include
hdl/rv32i_isa_pkg.sv
hdl/mem_stage_pkg.sv
hdl/ex_mem_capture.sv
hdl/dcache_port.sv
hdl/wb_select.sv
hdl/mem_stage.sv
sim/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - hdl/rv32i_isa_pkg.sv
  - hdl/mem_stage_pkg.sv
  - hdl/ex_mem_capture.sv
  - hdl/dcache_port.sv
  - hdl/wb_select.sv
  - hdl/mem_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_mem_stage.sv
